// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tbMmu
RTL_TOP ?= mmuTop
FILELIST ?= list.f
OBJDIR ?= obj_dir
VFLAGS ?= --timing --assert
PASS_TEXT ?= Verification passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(OBJDIR) -o $(TOP)
	@out="$$($(OBJDIR)/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJDIR)

// ==== cp0TlbPkg.sv ====
package cp0TlbPkg;

  // Word addresses on the Wishbone slave.
  localparam logic [2:0] regIndex = 3'd0;
  localparam logic [2:0] regEntryLo0 = 3'd1;
  localparam logic [2:0] regEntryLo1 = 3'd2;
  localparam logic [2:0] regEntryHi = 3'd3;
  localparam logic [2:0] regCommand = 3'd4;

  // Bits of the command register.
  localparam int cmdWrite = 0;
  localparam int cmdProbe = 1;

  // Index register layout.
  localparam int idxProbeBit = 31;
  localparam int idxLo = 0;

  // EntryLo0 and EntryLo1 share one layout.
  localparam int loPfnLo = 6;
  localparam int loCLo = 3;
  localparam int loDBit = 2;
  localparam int loVBit = 1;
  localparam int loGBit = 0;

  // EntryHi layout.
  localparam int hiVpn2Lo = 13;
  localparam int hiAsidLo = 0;

endpackage

// ==== list.f ====
tlbPkg.sv
cp0TlbPkg.sv
tlbLookup.sv
tlb.sv
tlbRegs.sv
mmuTop.sv
tbMmu.sv

// ==== mmuTop.sv ====
`timescale 1ns/1ps

module mmuTop import tlbPkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        wbCyc,
  input  logic        wbStb,
  input  logic        wbWe,
  input  logic [2:0]  wbAdr,
  input  logic [31:0] wbDatIn,
  output logic [31:0] wbDatOut,
  output logic        wbAck,
  input  logic [31:0] insAddrVirt,
  input  logic [31:0] dataAddrVirt,
  output logic        insMiss,
  output logic        insValid,
  output logic        insDirty,
  output logic        insBypassCache,
  output logic [31:0] insAddrPhy,
  output logic        dataMiss,
  output logic        dataValid,
  output logic        dataDirty,
  output logic        dataBypassCache,
  output logic [31:0] dataAddrPhy
);

  logic [31:0]          entryHi;
  logic [31:0]          entryLo0;
  logic [31:0]          entryLo1;
  logic [tlbIndexW-1:0] writeIndex;
  logic                 tlbWrite;
  logic                 tlbProbe;
  logic                 probeMiss;
  logic [tlbIndexW-1:0] probeIndex;

  tlbRegs u_regs (
    .clk(clk), .rst_n(rst_n),
    .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr),
    .wbDatIn(wbDatIn), .wbDatOut(wbDatOut), .wbAck(wbAck),
    .entryHi(entryHi), .entryLo0(entryLo0), .entryLo1(entryLo1),
    .writeIndex(writeIndex), .tlbWrite(tlbWrite), .tlbProbe(tlbProbe),
    .probeMiss(probeMiss), .probeIndex(probeIndex)
  );

  tlb u_tlb (
    .clk(clk), .rst_n(rst_n),
    .entryHi(entryHi), .entryLo0(entryLo0), .entryLo1(entryLo1),
    .writeIndex(writeIndex), .tlbWrite(tlbWrite), .tlbProbe(tlbProbe),
    .probeMiss(probeMiss), .probeIndex(probeIndex),
    .insAddrVirt(insAddrVirt), .dataAddrVirt(dataAddrVirt),
    .insMiss(insMiss), .insValid(insValid), .insDirty(insDirty),
    .insBypassCache(insBypassCache), .insAddrPhy(insAddrPhy),
    .dataMiss(dataMiss), .dataValid(dataValid), .dataDirty(dataDirty),
    .dataBypassCache(dataBypassCache), .dataAddrPhy(dataAddrPhy)
  );

endmodule

// ==== tbMmu.sv ====
`timescale 1ns/1ps

module tbMmu import tlbPkg::*, cp0TlbPkg::*; ();

  localparam int cycleLimit = 3000;

  logic        clk;
  logic        rst_n;
  logic        wbCyc, wbStb, wbWe, wbAck;
  logic [2:0]  wbAdr;
  logic [31:0] wbDatIn, wbDatOut;
  logic [31:0] insAddrVirt, dataAddrVirt, insAddrPhy, dataAddrPhy;
  logic        insMiss, insValid, insDirty, insBypassCache;
  logic        dataMiss, dataValid, dataDirty, dataBypassCache;

  // The reference copy of the TLB keeps the raw register words that were written.
  logic [vpn2W-1:0] mVpn2 [tlbEntries];
  logic [asidW-1:0] mAsid [tlbEntries];
  logic             mG [tlbEntries];
  logic [31:0]      mLo0 [tlbEntries];
  logic [31:0]      mLo1 [tlbEntries];
  logic [asidW-1:0] curAsid;

  logic [31:0] lfsrState = 32'h9670_f9a1;
  int          cycles = 0;
  int          checks = 0;
  int          errors = 0;

  mmuTop u_dut (
    .clk(clk), .rst_n(rst_n),
    .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr),
    .wbDatIn(wbDatIn), .wbDatOut(wbDatOut), .wbAck(wbAck),
    .insAddrVirt(insAddrVirt), .dataAddrVirt(dataAddrVirt),
    .insMiss(insMiss), .insValid(insValid), .insDirty(insDirty),
    .insBypassCache(insBypassCache), .insAddrPhy(insAddrPhy),
    .dataMiss(dataMiss), .dataValid(dataValid), .dataDirty(dataDirty),
    .dataBypassCache(dataBypassCache), .dataAddrPhy(dataAddrPhy)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycleLimit) begin
      $display("Timeout: the tests did not finish within %0d cycles", cycleLimit);
      $display("Verification failed");
      $finish;
    end
  end

  // The Galois LFSR steps once for each bit taken.
  function automatic logic [31:0] randBits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsrState[0]};
      lfsrState = (lfsrState >> 1) ^ (lfsrState[0] ? 32'h8020_0003 : 32'h0);
    end
    return r;
  endfunction

  function automatic logic [31:0] loWord(input logic [23:0] pfn, input logic [2:0] c,
                                         input logic d, input logic v, input logic g);
    return {2'b00, pfn, c, d, v, g};
  endfunction

  function automatic logic [31:0] hiWord(input logic [18:0] vpn2, input logic [7:0] asid);
    return {vpn2, 5'b0, asid};
  endfunction

  // Returns {miss, valid, dirty, bypass, physAddr}; the lowest matching entry wins.
  function automatic logic [35:0] expectXlate(input logic [31:0] va);
    logic [35:0] res;
    logic [31:0] lo;
    logic        found;
    res = 36'h8_0000_0000;
    found = 1'b0;
    for (int i = 0; i < tlbEntries; i++) begin
      if (!found && mVpn2[i] == va[31:13] && (mG[i] || mAsid[i] == curAsid)) begin
        found = 1'b1;
        lo = va[12] ? mLo1[i] : mLo0[i];
        res = {1'b0, lo[1], lo[2], lo[5:3] == 3'd2, lo[25:6], va[11:0]};
      end
    end
    return res;
  endfunction

  task automatic compareValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR %s: got 0x%08h, expected 0x%08h", name, got, exp);
    end
  endtask

  task automatic compareFlag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic wbAccess(input logic we, input logic [2:0] adr, input logic [31:0] data,
                          output logic [31:0] rdata);
    @(posedge clk);
    wbCyc <= 1'b1;
    wbStb <= 1'b1;
    wbWe <= we;
    wbAdr <= adr;
    wbDatIn <= data;
    @(negedge clk);
    while (!wbAck) @(negedge clk);
    rdata = wbDatOut;
    @(posedge clk);
    wbCyc <= 1'b0;
    wbStb <= 1'b0;
    wbWe <= 1'b0;
  endtask

  task automatic wbWrite(input logic [2:0] adr, input logic [31:0] data);
    logic [31:0] unused;
    wbAccess(1'b1, adr, data, unused);
    if (adr == regEntryHi) curAsid = data[7:0];
  endtask

  task automatic wbRead(input logic [2:0] adr, output logic [31:0] data);
    wbAccess(1'b0, adr, 32'h0, data);
  endtask

  task automatic writeReadBack(input logic [2:0] adr, input logic [31:0] wdata,
                               input logic [31:0] exp);
    logic [31:0] rd;
    wbWrite(adr, wdata);
    wbRead(adr, rd);
    compareValue("wbDatOut", rd, exp);
  endtask

  // An indexed write goes through the registers and is mirrored into the reference copy.
  task automatic writeEntry(input int idx, input logic [31:0] hi, input logic [31:0] lo0,
                            input logic [31:0] lo1);
    wbWrite(regIndex, 32'(idx));
    wbWrite(regEntryLo0, lo0);
    wbWrite(regEntryLo1, lo1);
    wbWrite(regEntryHi, hi);
    wbWrite(regCommand, 32'h1);
    mVpn2[idx] = hi[31:13];
    mAsid[idx] = hi[7:0];
    mG[idx] = lo0[0] & lo1[0];
    mLo0[idx] = lo0;
    mLo1[idx] = lo1;
  endtask

  task automatic checkXlate(input logic [31:0] insVa, input logic [31:0] dataVa);
    logic [35:0] expIns;
    logic [35:0] expData;
    @(posedge clk);
    insAddrVirt <= insVa;
    dataAddrVirt <= dataVa;
    @(negedge clk);
    expIns = expectXlate(insVa);
    expData = expectXlate(dataVa);
    compareFlag("insMiss", insMiss, expIns[35]);
    compareFlag("insValid", insValid, expIns[34]);
    compareFlag("insDirty", insDirty, expIns[33]);
    compareFlag("insBypassCache", insBypassCache, expIns[32]);
    compareValue("insAddrPhy", insAddrPhy, expIns[31:0]);
    compareFlag("dataMiss", dataMiss, expData[35]);
    compareFlag("dataValid", dataValid, expData[34]);
    compareFlag("dataDirty", dataDirty, expData[33]);
    compareFlag("dataBypassCache", dataBypassCache, expData[32]);
    compareValue("dataAddrPhy", dataAddrPhy, expData[31:0]);
  endtask

  task automatic testReset();
    logic [31:0] rd;
    for (int a = 0; a < 5; a++) begin
      wbRead(3'(a), rd);
      compareValue("wbDatOut", rd, 32'h0);
    end
    checkXlate(32'h0000_2000, 32'h0000_2000);
    checkXlate(32'h0000_0000, 32'h0000_0000);
  endtask

  task automatic testRegisters();
    writeReadBack(regIndex, 32'hffff_ffff, 32'h0000_000f);
    writeReadBack(regEntryLo0, 32'hffff_ffff, 32'h3fff_ffff);
    writeReadBack(regEntryLo1, 32'ha5a5_a5a5, 32'h25a5_a5a5);
    writeReadBack(regEntryHi, 32'hffff_ffff, 32'hffff_e0ff);
    writeReadBack(regCommand, 32'h0, 32'h0);
  endtask

  // Odd-numbered entries are global. Entry 5 has an invalid even page and 7 an invalid odd page.
  task automatic testTranslate();
    logic [23:0] pfn0;
    logic [23:0] pfn1;
    logic [18:0] vpn2;
    for (int i = 0; i < 8; i++) begin
      pfn0 = 24'(randBits(24));
      pfn1 = 24'(randBits(24));
      vpn2 = 19'h00100 + 19'(i * 5);
      writeEntry(i + 2, hiWord(vpn2, 8'h3c),
                 loWord(pfn0, 3'(i), i[1], i != 3, i[0]),
                 loWord(pfn1, 3'(i + 2), !i[1], i != 5, i[0]));
    end
    for (int i = 2; i < 10; i++) begin
      checkXlate({mVpn2[i], 13'h0a4c}, {mVpn2[i], 13'h1ff0});
      checkXlate({mVpn2[i], 13'h1004}, {mVpn2[i], 13'h0008});
    end
  endtask

  task automatic testAsid();
    wbWrite(regEntryHi, hiWord(19'h0, 8'h55));
    for (int i = 2; i < 10; i++) begin
      checkXlate({mVpn2[i], 13'h0123}, {mVpn2[i], 13'h1123});
    end
  endtask

  task automatic testProbe();
    logic [31:0] rd;
    wbWrite(regEntryHi, hiWord(mVpn2[6], 8'h3c));
    wbWrite(regCommand, 32'h2);
    wbRead(regIndex, rd);
    compareValue("Index", rd, 32'd6);
    // A global entry is found under any ASID.
    wbWrite(regEntryHi, hiWord(mVpn2[3], 8'h77));
    wbWrite(regCommand, 32'h2);
    wbRead(regIndex, rd);
    compareValue("Index", rd, 32'd3);
    wbWrite(regEntryHi, hiWord(19'h7ffff, 8'h3c));
    wbWrite(regCommand, 32'h2);
    wbRead(regIndex, rd);
    compareValue("Index", rd, 32'h8000_0000);
  endtask

  function automatic logic [31:0] pickAddr();
    int k;
    if (randBits(2) != 0) begin
      k = 2 + int'(randBits(3));
      return {mVpn2[k], 13'(randBits(13))};
    end
    return randBits(32);
  endfunction

  task automatic testRandom();
    logic [31:0] insVa;
    logic [31:0] dataVa;
    wbWrite(regEntryHi, hiWord(19'h0, 8'h3c));
    for (int n = 0; n < 200; n++) begin
      insVa = pickAddr();
      dataVa = pickAddr();
      checkXlate(insVa, dataVa);
    end
  endtask

  initial begin
    clk = 1'b0;
    rst_n <= 1'b0;
    wbCyc <= 1'b0;
    wbStb <= 1'b0;
    wbWe <= 1'b0;
    wbAdr <= 3'd0;
    wbDatIn <= 32'h0;
    insAddrVirt <= 32'h0;
    dataAddrVirt <= 32'h0;
    curAsid = 8'h0;
    for (int i = 0; i < tlbEntries; i++) begin
      mVpn2[i] = '0;
      mAsid[i] = '0;
      mG[i] = 1'b0;
      mLo0[i] = '0;
      mLo1[i] = '0;
    end
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    testReset();
    testRegisters();
    testTranslate();
    testAsid();
    testProbe();
    testRandom();
    @(posedge clk);
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// ==== tlb.sv ====
`timescale 1ns/1ps

module tlb import tlbPkg::*, cp0TlbPkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [31:0]          entryHi,
  input  logic [31:0]          entryLo0,
  input  logic [31:0]          entryLo1,
  input  logic [tlbIndexW-1:0] writeIndex,
  input  logic                 tlbWrite,
  input  logic                 tlbProbe,
  output logic                 probeMiss,
  output logic [tlbIndexW-1:0] probeIndex,
  input  logic [31:0]          insAddrVirt,
  input  logic [31:0]          dataAddrVirt,
  output logic                 insMiss,
  output logic                 insValid,
  output logic                 insDirty,
  output logic                 insBypassCache,
  output logic [31:0]          insAddrPhy,
  output logic                 dataMiss,
  output logic                 dataValid,
  output logic                 dataDirty,
  output logic                 dataBypassCache,
  output logic [31:0]          dataAddrPhy
);

  logic [entryW-1:0]            entryMem [tlbEntries];
  logic [tlbEntries*entryW-1:0] entryFlat;
  logic [entryW-1:0]            newEntry;
  logic [asidW-1:0]             curAsid;
  logic [31:0]                  probeAddr;

  // The G bit of an entry is set only when both halves are global.
  assign newEntry = {
    entryLo0[loCLo +: cacheW],
    entryLo1[loCLo +: cacheW],
    entryHi[hiAsidLo +: asidW],
    entryLo0[loGBit] & entryLo1[loGBit],
    entryHi[hiVpn2Lo +: vpn2W],
    entryLo1[loPfnLo +: pfnW],
    entryLo1[loDBit],
    entryLo1[loVBit],
    entryLo0[loPfnLo +: pfnW],
    entryLo0[loDBit],
    entryLo0[loVBit]
  };

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < tlbEntries; i++) begin
        entryMem[i] <= '0;
      end
    end else if (tlbWrite) begin
      entryMem[writeIndex] <= newEntry;
    end
  end

  for (genvar g = 0; g < tlbEntries; g++) begin : gFlatten
    assign entryFlat[g*entryW +: entryW] = entryMem[g];
  end

  assign curAsid = entryHi[hiAsidLo +: asidW];
  assign probeAddr = {entryHi[hiVpn2Lo +: vpn2W], {hiVpn2Lo{1'b0}}};

  tlbLookup u_insLookup (
    .entries(entryFlat), .virtAddr(insAddrVirt), .asid(curAsid),
    .miss(insMiss), .hitIndex(), .valid(insValid), .dirty(insDirty),
    .bypassCache(insBypassCache), .physAddr(insAddrPhy)
  );

  tlbLookup u_dataLookup (
    .entries(entryFlat), .virtAddr(dataAddrVirt), .asid(curAsid),
    .miss(dataMiss), .hitIndex(), .valid(dataValid), .dirty(dataDirty),
    .bypassCache(dataBypassCache), .physAddr(dataAddrPhy)
  );

  // The probe only needs to know which entry holds the pair.
  tlbLookup u_probeLookup (
    .entries(entryFlat), .virtAddr(probeAddr), .asid(curAsid),
    .miss(probeMiss), .hitIndex(probeIndex), .valid(), .dirty(),
    .bypassCache(), .physAddr()
  );

  // A probe that hits must name an entry that holds the probed page pair.
  probeHitNamesPair: assert property (@(posedge clk) disable iff (!rst_n)
    (tlbProbe && !probeMiss) |->
      (entryMem[probeIndex][vpn2Lo +: vpn2W] == entryHi[hiVpn2Lo +: vpn2W]));

endmodule

// ==== tlbLookup.sv ====
`timescale 1ns/1ps

module tlbLookup import tlbPkg::*; (
  input  logic [tlbEntries*entryW-1:0] entries,
  input  logic [31:0]                  virtAddr,
  input  logic [asidW-1:0]             asid,
  output logic                         miss,
  output logic [tlbIndexW-1:0]         hitIndex,
  output logic                         valid,
  output logic                         dirty,
  output logic                         bypassCache,
  output logic [31:0]                  physAddr
);

  logic [entryW-1:0]     entryArr [tlbEntries];
  logic [tlbEntries-1:0] matchVec;
  logic [tlbEntries-1:0] liveVec;
  logic [tlbIndexW-1:0]  hitIdx;
  logic                  hitV;
  logic                  hitD;
  logic [cacheW-1:0]     hitC;
  logic [ppnW-1:0]       hitPpn;

  for (genvar g = 0; g < tlbEntries; g++) begin : gMatch
    assign entryArr[g] = entries[g*entryW +: entryW];
    assign matchVec[g] = (entryArr[g][vpn2Lo +: vpn2W] == virtAddr[31:32-vpn2W])
                         && (entryArr[g][gBit] || entryArr[g][asidLo +: asidW] == asid);
    assign liveVec[g] = entryArr[g][v0Bit] || entryArr[g][v1Bit];
  end

  // Scan from the top so the lowest matching entry is the one reported.
  always_comb begin
    hitIdx = '0;
    hitV = 1'b0;
    hitD = 1'b0;
    hitC = '0;
    hitPpn = '0;
    for (int i = tlbEntries - 1; i >= 0; i--) begin
      if (matchVec[i]) begin
        hitIdx = tlbIndexW'(i);
        if (virtAddr[oddPageBit]) begin
          hitV = entryArr[i][v1Bit];
          hitD = entryArr[i][d1Bit];
          hitC = entryArr[i][c1Lo +: cacheW];
          hitPpn = entryArr[i][pfn1Lo +: ppnW];
        end else begin
          hitV = entryArr[i][v0Bit];
          hitD = entryArr[i][d0Bit];
          hitC = entryArr[i][c0Lo +: cacheW];
          hitPpn = entryArr[i][pfn0Lo +: ppnW];
        end
      end
    end
  end

  assign miss = ~|matchVec;
  assign hitIndex = hitIdx;
  assign valid = hitV;
  assign dirty = hitD;
  assign bypassCache = !miss && (hitC == cacheUncached);
  assign physAddr = miss ? '0 : {hitPpn, virtAddr[pageOffsetW-1:0]};

  // Cleared entries all alias page pair zero, so only entries with a valid half
  // are required to be unique.
  always_comb begin
    noMultiHit: assert #0 ($onehot0(matchVec & liveVec))
      else $error("tlbLookup: several live entries match one address");
  end

endmodule

// ==== tlbPkg.sv ====
package tlbPkg;

  // Geometry of the joint TLB.
  localparam int tlbEntries = 16;
  localparam int tlbIndexW = 4;

  // Field widths of one entry.
  localparam int vpn2W = 19;
  localparam int pfnW = 24;
  localparam int asidW = 8;
  localparam int cacheW = 3;

  // Cache attribute that makes an access bypass the cache.
  localparam logic [cacheW-1:0] cacheUncached = 3'd2;

  localparam int entryW = 86;

  // Low bit of each entry field, listed from the top of the entry down.
  localparam int c0Lo = 83;
  localparam int c1Lo = 80;
  localparam int asidLo = 72;
  localparam int gBit = 71;
  localparam int vpn2Lo = 52;
  localparam int pfn1Lo = 28;
  localparam int d1Bit = 27;
  localparam int v1Bit = 26;
  localparam int pfn0Lo = 2;
  localparam int d0Bit = 1;
  localparam int v0Bit = 0;

  // Only the low 20 PFN bits reach the 32-bit physical address.
  localparam int ppnW = 20;
  localparam int pageOffsetW = 12;

  // Virtual address bit that picks the odd page of a pair.
  localparam int oddPageBit = 12;

endpackage

// ==== tlbRegs.sv ====
`timescale 1ns/1ps

module tlbRegs import tlbPkg::*, cp0TlbPkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 wbCyc,
  input  logic                 wbStb,
  input  logic                 wbWe,
  input  logic [2:0]           wbAdr,
  input  logic [31:0]          wbDatIn,
  output logic [31:0]          wbDatOut,
  output logic                 wbAck,
  output logic [31:0]          entryHi,
  output logic [31:0]          entryLo0,
  output logic [31:0]          entryLo1,
  output logic [tlbIndexW-1:0] writeIndex,
  output logic                 tlbWrite,
  output logic                 tlbProbe,
  input  logic                 probeMiss,
  input  logic [tlbIndexW-1:0] probeIndex
);

  localparam int loBitsW = loPfnLo + pfnW;

  logic                 accept;
  logic                 cmdAccept;
  logic                 probeFail;
  logic [tlbIndexW-1:0] idxBits;
  logic [loBitsW-1:0]   lo0Bits;
  logic [loBitsW-1:0]   lo1Bits;
  logic [vpn2W-1:0]     hiVpn2;
  logic [asidW-1:0]     hiAsid;
  logic [31:0]          indexWord;

  // A request is taken once; the ack cycle itself is never a new request.
  assign accept = wbCyc && wbStb && !wbAck;
  assign cmdAccept = accept && wbWe && (wbAdr == regCommand);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wbAck <= 1'b0;
      tlbWrite <= 1'b0;
      tlbProbe <= 1'b0;
      probeFail <= 1'b0;
      idxBits <= '0;
      lo0Bits <= '0;
      lo1Bits <= '0;
      hiVpn2 <= '0;
      hiAsid <= '0;
    end else begin
      wbAck <= accept;
      tlbWrite <= cmdAccept && wbDatIn[cmdWrite];
      // A write command wins over a probe in the same word.
      tlbProbe <= cmdAccept && wbDatIn[cmdProbe] && !wbDatIn[cmdWrite];
      if (accept && wbWe) begin
        case (wbAdr)
          regIndex: idxBits <= wbDatIn[idxLo +: tlbIndexW];
          regEntryLo0: lo0Bits <= wbDatIn[loBitsW-1:0];
          regEntryLo1: lo1Bits <= wbDatIn[loBitsW-1:0];
          regEntryHi: begin
            hiVpn2 <= wbDatIn[hiVpn2Lo +: vpn2W];
            hiAsid <= wbDatIn[hiAsidLo +: asidW];
          end
          default: ;
        endcase
      end
      if (tlbProbe) begin
        probeFail <= probeMiss;
        idxBits <= probeIndex;
      end
    end
  end

  assign indexWord = {probeFail, {(idxProbeBit - tlbIndexW){1'b0}}, idxBits};
  assign entryLo0 = {{(32 - loBitsW){1'b0}}, lo0Bits};
  assign entryLo1 = {{(32 - loBitsW){1'b0}}, lo1Bits};
  assign entryHi = {hiVpn2, {(hiVpn2Lo - asidW){1'b0}}, hiAsid};
  assign writeIndex = idxBits;

  // The command register has no storage and reads as zero.
  always_comb begin
    case (wbAdr)
      regIndex: wbDatOut = indexWord;
      regEntryLo0: wbDatOut = entryLo0;
      regEntryLo1: wbDatOut = entryLo1;
      regEntryHi: wbDatOut = entryHi;
      default: wbDatOut = '0;
    endcase
  end

  ackInRequest: assert property (@(posedge clk) disable iff (!rst_n)
    wbAck |-> (wbCyc && wbStb));

  pulsesExclusive: assert property (@(posedge clk) disable iff (!rst_n)
    !(tlbWrite && tlbProbe));

  pulseOneCycle: assert property (@(posedge clk) disable iff (!rst_n)
    (tlbWrite || tlbProbe) |=> !(tlbWrite || tlbProbe));

endmodule
